// File: design/video_pkg.sv
`default_nettype none

package video_pkg;

        localparam int NUM_COLORS = 16;

        typedef logic [3:0] color_idx_t;
        typedef logic [5:0] luma_t;
        typedef logic [2:0] amp_t;      // 0 strongest, each step halves
        typedef logic [7:0] phase_t;    // 256 steps per turn

        localparam color_idx_t BLACK       = 4'd0;
        localparam color_idx_t WHITE       = 4'd1;
        localparam color_idx_t RED         = 4'd2;
        localparam color_idx_t CYAN        = 4'd3;
        localparam color_idx_t PURPLE      = 4'd4;
        localparam color_idx_t GREEN       = 4'd5;
        localparam color_idx_t BLUE        = 4'd6;
        localparam color_idx_t YELLOW      = 4'd7;
        localparam color_idx_t ORANGE      = 4'd8;
        localparam color_idx_t BROWN       = 4'd9;
        localparam color_idx_t PINK        = 4'd10;
        localparam color_idx_t DARK_GREY   = 4'd11;
        localparam color_idx_t GREY        = 4'd12;
        localparam color_idx_t LIGHT_GREEN = 4'd13;
        localparam color_idx_t LIGHT_BLUE  = 4'd14;
        localparam color_idx_t LIGHT_GREY  = 4'd15;

        localparam amp_t   AMP_NONE        = 3'b111;    // no modulation
        localparam phase_t SUBCARRIER_STEP = 8'd64;     // four clocks per cycle
        localparam phase_t BURST_PHASE     = 8'd128;    // 180 deg
        localparam amp_t   BURST_AMP       = 3'd2;
        localparam luma_t  SYNC_LUMA       = 6'd0;
        localparam luma_t  BLANK_LUMA      = 6'd18;     // blanking level

        typedef struct packed {
                luma_t  luma;
                amp_t   amp;
                phase_t phase;
        } palette_entry_t;

        typedef struct packed {
                logic       valid;
                color_idx_t index;
                logic       oddline;
                logic       sync;
                logic       burst;
        } pixel_t;

        typedef struct packed {
                color_idx_t     index;
                palette_entry_t entry;
        } pal_wr_t;

        typedef struct packed {
                logic           valid;
                logic           sync;
                logic           burst;
                palette_entry_t entry;  // phase already line adjusted
        } lookup_t;

        typedef struct packed {
                logic              valid;
                luma_t             luma;
                logic signed [7:0] chroma;
        } video_out_t;

        // sampled at the middle of each step so the mirror is exact
        localparam logic [6:0] SINE_QUARTER [16] = '{
                7'd6,   7'd19,  7'd31,  7'd43,  7'd54,  7'd65,  7'd76,  7'd85,
                7'd94,  7'd102, 7'd109, 7'd115, 7'd120, 7'd123, 7'd126, 7'd127
        };

        localparam palette_entry_t DEFAULT_PALETTE [NUM_COLORS] = '{
                BLACK:       '{luma: 6'd19, amp: AMP_NONE, phase: 8'd0},
                WHITE:       '{luma: 6'd59, amp: AMP_NONE, phase: 8'd0},
                RED:         '{luma: 6'd31, amp: 3'd2,     phase: 8'd80},   // 112.5 deg
                CYAN:        '{luma: 6'd44, amp: 3'd2,     phase: 8'd208},  // 292.5 deg
                PURPLE:      '{luma: 6'd34, amp: 3'd1,     phase: 8'd32},
                GREEN:       '{luma: 6'd39, amp: 3'd1,     phase: 8'd160},
                BLUE:        '{luma: 6'd28, amp: 3'd2,     phase: 8'd0},
                YELLOW:      '{luma: 6'd50, amp: 3'd0,     phase: 8'd128},
                ORANGE:      '{luma: 6'd34, amp: 3'd0,     phase: 8'd96},
                BROWN:       '{luma: 6'd28, amp: 3'd2,     phase: 8'd112},
                PINK:        '{luma: 6'd39, amp: 3'd2,     phase: 8'd80},
                DARK_GREY:   '{luma: 6'd31, amp: AMP_NONE, phase: 8'd0},
                GREY:        '{luma: 6'd38, amp: AMP_NONE, phase: 8'd0},
                LIGHT_GREEN: '{luma: 6'd50, amp: 3'd2,     phase: 8'd160},
                LIGHT_BLUE:  '{luma: 6'd38, amp: 3'd2,     phase: 8'd0},
                LIGHT_GREY:  '{luma: 6'd44, amp: AMP_NONE, phase: 8'd0}
        };

endpackage : video_pkg

`default_nettype wire

// File: design/palette_regs.sv
`timescale 1ns/1ps
`default_nettype none

module palette_regs (
        input  logic                      clk_i,
        input  logic                      rst_n_i,
        input  logic                      pal_req_i,
        input  video_pkg::pal_wr_t        pal_wr_i,
        output logic                      pal_ack_o,
        output video_pkg::palette_entry_t pal_table_o [video_pkg::NUM_COLORS]
);

        import video_pkg::*;

        typedef enum logic {
                ACK_IDLE,
                ACK_HELD
        } ack_state_e;

        ack_state_e state_q;
        ack_state_e state_d;
        logic       wr_en;

        // accept on the first cycle of a new request
        assign wr_en = pal_req_i && (state_q == ACK_IDLE);

        always_comb begin
                state_d = state_q;
                case (state_q)
                        ACK_IDLE: begin
                                if (pal_req_i) begin
                                        state_d = ACK_HELD;
                                end
                        end
                        ACK_HELD: begin
                                if (!pal_req_i) begin       // host released req
                                        state_d = ACK_IDLE;
                                end
                        end
                        default: state_d = ACK_IDLE;
                endcase
        end

        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        state_q <= ACK_IDLE;
                end else begin
                        state_q <= state_d;
                end
        end

        assign pal_ack_o = (state_q == ACK_HELD);

        // one register per colour, written on its own index
        for (genvar g = 0; g < NUM_COLORS; g++) begin : g_entry
                palette_entry_t entry_q;
                logic           hit;

                assign hit = wr_en && (pal_wr_i.index == color_idx_t'(g));

                always_ff @(posedge clk_i or negedge rst_n_i) begin
                        if (!rst_n_i) begin
                                entry_q <= DEFAULT_PALETTE[g];
                        end else if (hit) begin
                                entry_q <= pal_wr_i.entry;
                        end
                end

                assign pal_table_o[g] = entry_q;    // visible to lookup at once
        end

endmodule : palette_regs

`default_nettype wire

// File: design/color_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module color_lookup (
        input  logic                      clk_i,
        input  logic                      rst_n_i,
        input  video_pkg::pixel_t         pix_i,
        input  video_pkg::palette_entry_t pal_table_i [video_pkg::NUM_COLORS],
        output video_pkg::lookup_t        lk_o
);

        import video_pkg::*;

        palette_entry_t sel;
        palette_entry_t sel_adj;
        palette_entry_t entry_q;
        logic           valid_q;
        logic           sync_q;
        logic           burst_q;

        assign sel = pal_table_i[pix_i.index];

        // PAL style alternation, odd lines run the phase backwards
        always_comb begin
                sel_adj = sel;
                if (pix_i.oddline) begin
                        sel_adj.phase = 8'd0 - sel.phase;   // 256 minus phase
                end
        end

        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        valid_q <= 1'b0;
                        sync_q  <= 1'b0;
                        burst_q <= 1'b0;
                end else begin
                        valid_q <= pix_i.valid;
                        sync_q  <= pix_i.sync;
                        burst_q <= pix_i.burst;
                end
        end

        always_ff @(posedge clk_i) begin
                entry_q <= sel_adj;     // flags decide if it is used
        end

        assign lk_o = '{
                valid: valid_q,
                sync:  sync_q,
                burst: burst_q,
                entry: entry_q
        };

endmodule : color_lookup

`default_nettype wire

// File: design/chroma_gen.sv
`timescale 1ns/1ps
`default_nettype none

module chroma_gen (
        input  logic                   clk_i,
        input  logic                   rst_n_i,
        input  video_pkg::lookup_t     lk_i,
        output video_pkg::video_out_t  video_o
);

        import video_pkg::*;

        phase_t            acc_q;
        phase_t            acc_next;
        phase_t            eff_phase;
        amp_t              eff_amp;
        logic [3:0]        sine_idx;
        logic [6:0]        sine_mag;
        logic [6:0]        scaled;
        logic signed [7:0] wave;
        luma_t             out_luma;
        logic signed [7:0] out_chroma;
        video_out_t        video_q;

        // free running subcarrier, independent of pixel valid
        assign acc_next = acc_q + SUBCARRIER_STEP;

        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        acc_q <= '0;
                end else begin
                        acc_q <= acc_next;
                end
        end

        // acc_next is the accumulator value while this result is on video_o
        always_comb begin
                if (lk_i.burst) begin
                        eff_phase = acc_next + BURST_PHASE;     // no line alternation
                        eff_amp   = BURST_AMP;
                end else begin
                        eff_phase = acc_next + lk_i.entry.phase;
                        eff_amp   = lk_i.entry.amp;
                end
        end

        // quarter table, mirrored in quadrants 1 and 3
        assign sine_idx = eff_phase[6] ? ~eff_phase[5:2] : eff_phase[5:2];
        assign sine_mag = SINE_QUARTER[sine_idx];
        assign scaled   = (eff_amp == AMP_NONE) ? 7'd0 : (sine_mag >> eff_amp);

        // second half of the turn is negative
        assign wave = eff_phase[7] ? -$signed({1'b0, scaled}) : $signed({1'b0, scaled});

        // sync wins over burst, burst over blanking
        always_comb begin
                if (lk_i.sync) begin
                        out_luma   = SYNC_LUMA;
                        out_chroma = 8'sd0;
                end else if (lk_i.burst) begin
                        out_luma   = BLANK_LUMA;
                        out_chroma = wave;
                end else if (!lk_i.valid) begin
                        out_luma   = BLANK_LUMA;
                        out_chroma = 8'sd0;
                end else begin
                        out_luma   = lk_i.entry.luma;
                        out_chroma = wave;
                end
        end

        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        video_q <= '{valid: 1'b0, luma: BLANK_LUMA, chroma: 8'sd0};
                end else begin
                        video_q.valid  <= lk_i.valid;
                        video_q.luma   <= out_luma;
                        video_q.chroma <= out_chroma;
                end
        end

        assign video_o = video_q;

endmodule : chroma_gen

`default_nettype wire

// File: design/video_encoder_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_encoder_top (
        input  logic                   clk_i,
        input  logic                   rst_n_i,
        input  video_pkg::pixel_t      pix_i,
        input  logic                   pal_req_i,
        input  video_pkg::pal_wr_t     pal_wr_i,
        output logic                   pal_ack_o,
        output video_pkg::video_out_t  video_o
);

        import video_pkg::*;

        palette_entry_t pal_table [NUM_COLORS];     // live palette, combinational
        lookup_t        lk_out;                     // stage 1 result

        palette_regs i_palette_regs (
                .clk_i       (clk_i),
                .rst_n_i     (rst_n_i),
                .pal_req_i   (pal_req_i),
                .pal_wr_i    (pal_wr_i),
                .pal_ack_o   (pal_ack_o),
                .pal_table_o (pal_table)
        );

        color_lookup i_color_lookup (
                .clk_i       (clk_i),
                .rst_n_i     (rst_n_i),
                .pix_i       (pix_i),
                .pal_table_i (pal_table),
                .lk_o        (lk_out)
        );

        chroma_gen i_chroma_gen (
                .clk_i       (clk_i),
                .rst_n_i     (rst_n_i),
                .lk_i        (lk_out),
                .video_o     (video_o)
        );

endmodule : video_encoder_top

`default_nettype wire

// File: bench/video_checker.sv
`timescale 1ns/1ps
`default_nettype none

module video_checker (
        input  logic                  clk_i,
        input  logic                  rst_n_i,
        input  video_pkg::pixel_t     pix_i,
        input  logic                  pal_req_i,
        input  video_pkg::pal_wr_t    pal_wr_i,
        input  logic                  ack_i,
        input  video_pkg::video_out_t video_i,
        output int                    errors_o
);

        import video_pkg::*;

        palette_entry_t pal_copy [NUM_COLORS];  // model of the live palette
        lookup_t        stage1;
        lookup_t        stage2;
        phase_t         acc;
        logic           ack_exp;
        int             errors = 0;

        assign errors_o = errors;

        // quarter wave folded out to a full turn
        function automatic logic signed [7:0] ref_chroma(input phase_t p, input amp_t a);
                logic [1:0]        quad;
                logic [3:0]        idx;
                logic [6:0]        mag;
                logic signed [7:0] res;
                quad = p[7:6];
                idx  = p[5:2];
                if (quad == 2'd1 || quad == 2'd3) begin
                        idx = 4'd15 - idx;      // falling half of the quadrant pair
                end
                mag = SINE_QUARTER[idx];
                mag = (a == AMP_NONE) ? 7'd0 : (mag >> a);
                res = {1'b0, mag};
                if (quad[1]) begin
                        res = -res;
                end
                return res;
        endfunction

        function automatic video_out_t expected_out(input lookup_t s, input phase_t a);
                video_out_t e;
                e.valid  = s.valid;
                e.luma   = BLANK_LUMA;
                e.chroma = 8'sd0;
                if (s.sync) begin
                        e.luma = SYNC_LUMA;
                end else if (s.burst) begin
                        e.chroma = ref_chroma(a + BURST_PHASE, BURST_AMP);
                end else if (s.valid) begin
                        e.luma   = s.entry.luma;
                        e.chroma = ref_chroma(a + s.entry.phase, s.entry.amp);
                end
                return e;
        endfunction

        task automatic compare(input string name, input logic [7:0] expv,
                               input logic [7:0] gotv);
                if (gotv !== expv) begin
                        errors++;
                        $display("Error: %s expected 0x%h got 0x%h at %0t", name, expv, gotv,
                                 $time);
                end
        endtask

        // subcarrier counted from reset release
        always @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        acc <= '0;
                end else begin
                        acc <= acc + SUBCARRIER_STEP;
                end
        end

        // everything is sampled mid cycle where DUT signals are settled
        always @(negedge clk_i) begin : check_cycle
                video_out_t     exp_v;
                palette_entry_t sel;
                if (!rst_n_i) begin
                        pal_copy = DEFAULT_PALETTE;
                        stage1   = '0;
                        stage2   = '0;
                        ack_exp  = 1'b0;
                        compare("video_o.valid", 8'(1'b0), 8'(video_i.valid));
                        compare("pal_ack_o", 8'(1'b0), 8'(ack_i));
                end else begin
                        exp_v = expected_out(stage2, acc);
                        compare("video_o.valid", 8'(exp_v.valid), 8'(video_i.valid));
                        compare("video_o.luma", 8'(exp_v.luma), 8'(video_i.luma));
                        compare("video_o.chroma", 8'(exp_v.chroma), 8'(video_i.chroma));
                        compare("pal_ack_o", 8'(ack_exp), 8'(ack_i));
                        sel = pal_copy[pix_i.index];
                        if (pix_i.oddline) begin
                                sel.phase = phase_t'(9'd256 - {1'b0, sel.phase});
                        end
                        stage2 = stage1;
                        stage1 = '{valid: pix_i.valid, sync: pix_i.sync, burst: pix_i.burst,
                                   entry: sel};
                        if (pal_req_i && !ack_exp) begin
                                pal_copy[pal_wr_i.index] = pal_wr_i.entry;  // new handshake
                        end
                        ack_exp = pal_req_i;    // ack follows req one clock late
                end
        end

endmodule : video_checker

`default_nettype wire

// File: bench/video_encoder_props.sv
`timescale 1ns/1ps
`default_nettype none

module video_encoder_props (
        input logic                  clk_i,
        input logic                  rst_n_i,
        input logic                  pal_req_i,
        input logic                  pal_ack_i,
        input video_pkg::pixel_t     pix_i,
        input video_pkg::video_out_t video_i
);

        // ack only answers a request seen on the previous clock
        ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                $rose(pal_ack_i) |-> $past(pal_req_i))
                else $error("pal_ack_o rose without a pending request");

        ack_holds: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                (pal_ack_i && pal_req_i) |=> pal_ack_i)
                else $error("pal_ack_o dropped while pal_req_i was still high");

        // two register stages between pixel in and video out
        valid_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                video_i.valid == $past(pix_i.valid, 2))
                else $error("video_o.valid does not follow pix_i.valid two cycles later");

endmodule : video_encoder_props

bind video_encoder_top video_encoder_props i_video_encoder_props (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .pal_req_i (pal_req_i),
        .pal_ack_i (pal_ack_o),
        .pix_i     (pix_i),
        .video_i   (video_o)
);

`default_nettype wire

// File: bench/tb_video_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_video_encoder;

        import video_pkg::*;

        typedef enum logic [1:0] {
                OP_PIXEL,       // index steps up by one per repeat
                OP_RANDOM,
                OP_WRITE,
                OP_RESET
        } op_e;

        typedef struct packed {
                op_e            op;
                color_idx_t     index;
                logic           oddline;
                logic           sync;
                logic           burst;
                logic           valid;
                logic [7:0]     count;
                palette_entry_t entry;
        } stim_row_t;

        localparam int             NUM_ROWS = 13;
        localparam int             HS_LIMIT = 8;
        localparam palette_entry_t NO_ENTRY = '0;

        localparam stim_row_t STIM [NUM_ROWS] = '{
                '{OP_PIXEL,  BLACK,  1'b0, 1'b0, 1'b0, 1'b1, 8'd16, NO_ENTRY},
                '{OP_PIXEL,  BLACK,  1'b1, 1'b0, 1'b0, 1'b1, 8'd16, NO_ENTRY},
                '{OP_PIXEL,  BLACK,  1'b0, 1'b1, 1'b0, 1'b0, 8'd4,  NO_ENTRY},
                '{OP_PIXEL,  BLACK,  1'b1, 1'b0, 1'b1, 1'b0, 8'd4,  NO_ENTRY},
                '{OP_PIXEL,  YELLOW, 1'b0, 1'b0, 1'b0, 1'b0, 8'd3,  NO_ENTRY},
                '{OP_WRITE,  RED,    1'b0, 1'b0, 1'b0, 1'b1, 8'd0,  '{6'd45, 3'd1, 8'd200}},
                '{OP_PIXEL,  BLACK,  1'b0, 1'b0, 1'b0, 1'b1, 8'd16, NO_ENTRY},
                '{OP_PIXEL,  BLACK,  1'b1, 1'b0, 1'b0, 1'b1, 8'd16, NO_ENTRY},
                '{OP_WRITE,  BLACK,  1'b0, 1'b0, 1'b0, 1'b1, 8'd0,  '{6'd22, 3'd0, 8'd40}},
                '{OP_RANDOM, BLACK,  1'b0, 1'b0, 1'b0, 1'b1, 8'd64, NO_ENTRY},
                '{OP_RESET,  BLACK,  1'b0, 1'b0, 1'b0, 1'b0, 8'd3,  NO_ENTRY},
                '{OP_PIXEL,  BLACK,  1'b0, 1'b0, 1'b0, 1'b1, 8'd16, NO_ENTRY},
                '{OP_PIXEL,  BLACK,  1'b0, 1'b0, 1'b0, 1'b0, 8'd4,  NO_ENTRY}
        };

        logic       clk_i = 1'b0;
        logic       rst_n_i;
        pixel_t     pix_i;
        logic       pal_req_i;
        pal_wr_t    pal_wr_i;
        logic       pal_ack_o;
        video_out_t video_o;
        int         chk_errors;
        int         hs_errors = 0;
        int         cycle_count = 0;
        int         cycle_limit;
        logic [31:0] lfsr = 32'h0bbc19b7;

        video_encoder_top i_video_encoder_top (.*);

        video_checker i_video_checker (
                .clk_i     (clk_i),
                .rst_n_i   (rst_n_i),
                .pix_i     (pix_i),
                .pal_req_i (pal_req_i),
                .pal_wr_i  (pal_wr_i),
                .ack_i     (pal_ack_o),
                .video_i   (video_o),
                .errors_o  (chk_errors)
        );

        initial begin
                forever #10 clk_i = ~clk_i;
        end

        // right shift Galois form of x^32 + x^22 + x^2 + x + 1
        function automatic logic [31:0] lfsr_step(input logic [31:0] s);
                if (s[0]) begin
                        return (s >> 1) ^ 32'h80200003;
                end
                return s >> 1;
        endfunction

        task automatic take_bit(output logic b);
                lfsr = lfsr_step(lfsr);
                b    = lfsr[0];
        endtask

        function automatic int total_cycles();
                int sum;
                sum = 12;       // first reset and its release
                for (int i = 0; i < NUM_ROWS; i++) begin
                        case (STIM[i].op)
                                OP_WRITE: sum += 6;
                                OP_RESET: sum += int'(STIM[i].count) + 2;
                                default:  sum += int'(STIM[i].count);
                        endcase
                end
                return sum;
        endfunction

        task automatic apply_reset(input int cycles);
                @(posedge clk_i);
                rst_n_i   <= 1'b0;
                pix_i     <= '0;
                pal_req_i <= 1'b0;
                repeat (cycles) @(posedge clk_i);
                rst_n_i <= 1'b1;
        endtask

        // pixels of the written colour keep flowing through the handshake
        task automatic write_palette(input pal_wr_t w);
                int waited;
                @(posedge clk_i);
                pal_wr_i  <= w;
                pal_req_i <= 1'b1;
                pix_i     <= '{valid: 1'b1, index: w.index, oddline: 1'b0, sync: 1'b0,
                               burst: 1'b0};
                waited = 0;
                @(negedge clk_i);
                while (!pal_ack_o && waited < HS_LIMIT) begin
                        @(negedge clk_i);
                        waited++;
                end
                if (!pal_ack_o) begin
                        hs_errors++;
                        $display("Handshake failure: pal_ack_o never rose after the request");
                end
                @(posedge clk_i);
                pal_req_i <= 1'b0;
                waited = 0;
                @(negedge clk_i);
                while (pal_ack_o && waited < HS_LIMIT) begin
                        @(negedge clk_i);
                        waited++;
                end
                if (pal_ack_o) begin
                        hs_errors++;
                        $display("Handshake failure: pal_ack_o stayed high after req dropped");
                end
        endtask

        task automatic run_row(input stim_row_t r);
                color_idx_t idx;
                logic       b;
                logic       odd;
                case (r.op)
                        OP_PIXEL: begin
                                for (int n = 0; n < int'(r.count); n++) begin
                                        idx = r.index + 4'(n);
                                        @(posedge clk_i);
                                        pix_i <= '{valid: r.valid, index: idx,
                                                   oddline: r.oddline, sync: r.sync,
                                                   burst: r.burst};
                                end
                        end
                        OP_RANDOM: begin
                                for (int n = 0; n < int'(r.count); n++) begin
                                        idx = '0;
                                        for (int k = 0; k < 4; k++) begin
                                                take_bit(b);
                                                idx = {idx[2:0], b};
                                        end
                                        take_bit(odd);
                                        @(posedge clk_i);
                                        pix_i <= '{valid: 1'b1, index: idx, oddline: odd,
                                                   sync: 1'b0, burst: 1'b0};
                                end
                        end
                        OP_WRITE: write_palette('{index: r.index, entry: r.entry});
                        default:  apply_reset(int'(r.count));
                endcase
        endtask

        initial begin
                rst_n_i   = 1'b0;
                pix_i     = '0;
                pal_req_i = 1'b0;
                pal_wr_i  = '0;
                repeat (10) @(posedge clk_i);
                rst_n_i <= 1'b1;
                for (int i = 0; i < NUM_ROWS; i++) begin
                        run_row(STIM[i]);
                end
                @(negedge clk_i);       // let the last compare land
                @(posedge clk_i);       // counts are settled here
                $display("Closing report: %0d value errors, %0d handshake errors",
                         chk_errors, hs_errors);
                if (chk_errors == 0 && hs_errors == 0) begin
                        $display("No errors");
                end else begin
                        $display("Errors found");
                end
                $finish;
        end

        initial begin
                cycle_limit = total_cycles() + 50;
                while (cycle_count < cycle_limit) begin
                        @(posedge clk_i);
                        cycle_count++;
                end
                $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
                $display("Errors found");
                $finish;
        end

endmodule : tb_video_encoder

`default_nettype wire

// File: sim.f
design/video_pkg.sv
design/palette_regs.sv
design/color_lookup.sv
design/chroma_gen.sv
design/video_encoder_top.sv
bench/video_checker.sv
bench/video_encoder_props.sv
bench/tb_video_encoder.sv

// File: run_sim.sh
#!/bin/sh
# build the video encoder testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_video_encoder -f sim.f -o tb_video_encoder \
        && ./obj_dir/tb_video_encoder > sim.log 2>&1 \
        || { echo "FAIL: build or simulation did not complete, see sim.log"; exit 1; }
grep -q "Errors found" sim.log && { echo "FAIL: errors reported in sim.log"; exit 1; }
echo "PASS"
exit 0
